// ==== Bender.yml ====
package:
  name: icache_tag_lookup

sources:
  - logic/icache_pkg.sv
  - logic/icache_tag_ram.sv
  - logic/icache_lookup.sv
  - logic/icache_result_fifo.sv
  - logic/icache_refill_alloc.sv
  - logic/icache_top.sv
  - target: test
    files:
      - verification/icache_chk.sv
      - verification/icache_tb.sv

// ==== compile.f ====
logic/icache_pkg.sv
logic/icache_tag_ram.sv
logic/icache_lookup.sv
logic/icache_result_fifo.sv
logic/icache_refill_alloc.sv
logic/icache_top.sv
verification/icache_chk.sv
verification/icache_tb.sv

// ==== logic/icache_lookup.sv ====
/*
 * Tag lookup stage
 *  - accepts fetch requests on a valid/ready handshake
 *  - reads the indexed set and compares all ways
 *  - pushes hit or miss results under a credit counter
 */
`timescale 1ns/10ps

module icache_lookup import icache_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic req_valid,
	input  fetch_addr_t req_addr,
	output logic req_ready,
	output line_index_t rd_index,
	input  tag_t rd_tags [WAYS],
	input  logic [WAYS-1:0] rd_valid,
	output logic push,
	output fetch_addr_t push_addr,
	output logic push_hit,
	output way_t push_way,
	input  logic credit_return
);

	lookup_state_t state;
	fetch_addr_t addr_q;
	logic hit_q;
	way_t way_q;
	logic cmp_hit;
	way_t cmp_way;
	credit_cnt_t credits;
	logic accept;

	assign req_ready = (state == IDLE);
	assign accept = req_valid && req_ready;

	// The tag RAM registers this, so only the accept cycle value matters
	assign rd_index = (state == IDLE) ? addr_index(req_addr) : addr_index(addr_q);

	// ==================================================
	// Way compare
	// ==================================================
	// Scanning down lets the lowest matching way win
	always_comb begin
		cmp_hit = 1'b0;
		cmp_way = '0;
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (rd_valid[w] && (rd_tags[w] == addr_tag(addr_q))) begin
				cmp_hit = 1'b1;
				cmp_way = way_t'(w);
			end
		end
	end

	// A result may go out straight from READ, or later from PUSH when stalled
	assign push = ((state == READ) || (state == PUSH)) && (credits != '0);
	assign push_addr = addr_q;
	assign push_hit = (state == PUSH) ? hit_q : cmp_hit;
	assign push_way = (state == PUSH) ? way_q : cmp_way;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: if (accept) state <= READ;
				READ: state <= push ? IDLE : PUSH;
				PUSH: if (push) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// Result is frozen on leaving READ so later fills cannot change it
	always_ff @(posedge clk) begin
		if (accept) addr_q <= req_addr;
		if (state == READ) begin
			hit_q <= cmp_hit;
			way_q <= cmp_way;
		end
	end

	// One credit per free buffer entry
	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= credit_cnt_t'(RESULT_DEPTH);
		end else begin
			credits <= credits + credit_cnt_t'(credit_return) - credit_cnt_t'(push);
		end
	end

endmodule

// ==== logic/icache_pkg.sv ====
/*
 * Shared definitions for the instruction-cache tag lookup
 *  - cache geometry and address field positions
 *  - result buffer depth and response credit count
 *  - vector types for addresses, tags, set indices, ways and credits
 *  - field extraction helpers and the lookup FSM encoding
 */
package icache_pkg;

	// ==================================================
	// Geometry
	// ==================================================
	localparam int LINES = 256;
	localparam int WAYS = 4;
	// Lowest set index bit, below it sits the 64-byte line offset
	localparam int LOBIT = 6;
	// Lowest tag bit, the set index fills LOBIT up to here
	localparam int TAGBIT = 14;

	// ==================================================
	// Flow control
	// ==================================================
	// Result buffer entries, which is also the lookup's starting credit
	localparam int RESULT_DEPTH = 4;
	localparam int RSP_CREDITS = 2;

	typedef logic [31:0] fetch_addr_t;
	typedef logic [$bits(fetch_addr_t)-TAGBIT-1:0] tag_t;
	typedef logic [$clog2(LINES)-1:0] line_index_t;
	typedef logic [$clog2(WAYS)-1:0] way_t;
	// Must hold the full count RESULT_DEPTH, hence the extra bit
	typedef logic [$clog2(RESULT_DEPTH+1)-1:0] credit_cnt_t;

	typedef enum logic [1:0] {IDLE, READ, PUSH} lookup_state_t;

	// Tag field of a fetch address
	function automatic tag_t addr_tag(input fetch_addr_t addr);
		return addr[$bits(fetch_addr_t)-1:TAGBIT];
	endfunction

	// Set index field of a fetch address
	function automatic line_index_t addr_index(input fetch_addr_t addr);
		return addr[TAGBIT-1:LOBIT];
	endfunction

endpackage

// ==== logic/icache_refill_alloc.sv ====
/*
 * Refill allocator
 *  - drains the result buffer one entry at a time
 *  - issues responses under credits from the sink
 *  - on a miss picks a victim by global round robin and fills the tag
 */
`timescale 1ns/10ps

module icache_refill_alloc import icache_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic head_valid,
	input  fetch_addr_t head_addr,
	input  logic head_hit,
	input  way_t head_way,
	output logic pop,
	output logic rsp_valid,
	output fetch_addr_t rsp_addr,
	output logic rsp_hit,
	output way_t rsp_way,
	input  logic rsp_credit,
	output logic wr,
	output fetch_addr_t wr_addr,
	output way_t wr_way
);

	credit_cnt_t rsp_cnt;
	way_t victim;
	// Head is claimed this cycle and answered on the next
	logic arm;
	logic issue;

	// The credit is reserved when arming, so issue always has one in hand
	assign arm = head_valid && !issue && (rsp_cnt != '0);

	// ==================================================
	// Response and fill outputs
	// ==================================================
	// Pop, response and fill all happen in the issue cycle
	assign pop = issue;
	assign rsp_valid = issue;
	assign rsp_addr = head_addr;
	assign rsp_hit = head_hit;
	assign rsp_way = head_hit ? head_way : victim;

	// Writing the tag at once stands in for the line refill
	assign wr = issue && !head_hit;
	assign wr_addr = head_addr;
	assign wr_way = victim;

	always_ff @(posedge clk) begin
		if (rst) begin
			issue <= 1'b0;
			rsp_cnt <= credit_cnt_t'(RSP_CREDITS);
			victim <= '0;
		end else begin
			issue <= arm;
			rsp_cnt <= rsp_cnt + credit_cnt_t'(rsp_credit) - credit_cnt_t'(arm);
			// One counter for all sets, stepped only by misses
			if (wr) begin
				victim <= victim + 1'b1;
			end
		end
	end

endmodule

// ==== logic/icache_result_fifo.sv ====
/*
 * Lookup result buffer
 *  - circular queue of address, hit flag and way
 *  - head presented to the refill allocator
 *  - one credit pulse back to the lookup for every pop
 */
`timescale 1ns/10ps

module icache_result_fifo import icache_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic push,
	input  fetch_addr_t push_addr,
	input  logic push_hit,
	input  way_t push_way,
	input  logic pop,
	output logic head_valid,
	output fetch_addr_t head_addr,
	output logic head_hit,
	output way_t head_way,
	output logic credit_return
);

	// Entry storage
	fetch_addr_t mem_addr [RESULT_DEPTH];
	logic mem_hit [RESULT_DEPTH];
	way_t mem_way [RESULT_DEPTH];

	// Pointers wrap on their own since the depth is a power of two
	logic [$clog2(RESULT_DEPTH)-1:0] wr_ptr;
	logic [$clog2(RESULT_DEPTH)-1:0] rd_ptr;
	credit_cnt_t count;

	// ==================================================
	// Storage and pointers
	// ==================================================
	always_ff @(posedge clk) begin
		if (push) begin
			mem_addr[wr_ptr] <= push_addr;
			mem_hit[wr_ptr] <= push_hit;
			mem_way[wr_ptr] <= push_way;
		end
	end

	// No full check here, the lookup never pushes without a credit
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_return <= 1'b0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			count <= count + credit_cnt_t'(push) - credit_cnt_t'(pop);
			// The freed entry is handed back one cycle after the pop
			credit_return <= pop;
		end
	end

	// Head fields are only meaningful while head_valid is high
	assign head_valid = (count != '0);
	assign head_addr = mem_addr[rd_ptr];
	assign head_hit = mem_hit[rd_ptr];
	assign head_way = mem_way[rd_ptr];

endmodule

// ==== logic/icache_tag_ram.sv ====
/*
 * Four-way tag array
 *  - tag storage without reset, valid bits in flip-flops
 *  - one write port used by the refill allocator
 *  - registered read index, all ways read together
 */
`timescale 1ns/10ps

module icache_tag_ram import icache_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic wr,
	input  fetch_addr_t wr_addr,
	input  way_t wr_way,
	input  line_index_t rd_index,
	output tag_t rd_tags [WAYS],
	output logic [WAYS-1:0] rd_valid
);

	// Tag values carry no meaning until their valid bit is set
	tag_t tags [WAYS][LINES];
	// One valid bit per way for every set
	logic [WAYS-1:0] valid [LINES];
	line_index_t rd_index_q;

	// ==================================================
	// Write port
	// ==================================================
	always_ff @(posedge clk) begin
		if (wr) begin
			tags[wr_way][addr_index(wr_addr)] <= addr_tag(wr_addr);
		end
	end

	// Valid bits are cleared by reset so every set starts empty
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < LINES; s++) begin
				valid[s] <= '0;
			end
		end else if (wr) begin
			valid[addr_index(wr_addr)][wr_way] <= 1'b1;
		end
	end

	// ==================================================
	// Read port
	// ==================================================
	// The index is captured on the request cycle, data shows up the cycle after
	always_ff @(posedge clk) begin
		rd_index_q <= rd_index;
	end

	// A write to the held set is visible on the very next cycle
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			rd_tags[w] = tags[w][rd_index_q];
		end
	end

	assign rd_valid = valid[rd_index_q];

endmodule

// ==== logic/icache_top.sv ====
/*
 * Instruction-cache tag lookup top level
 *  - tag RAM, lookup stage, result buffer and refill allocator
 *  - valid/ready request side, credit-controlled response side
 */
`timescale 1ns/10ps

module icache_top import icache_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic req_valid,
	input  fetch_addr_t req_addr,
	output logic req_ready,
	output logic rsp_valid,
	output fetch_addr_t rsp_addr,
	output logic rsp_hit,
	output way_t rsp_way,
	input  logic rsp_credit
);

	// ==================================================
	// Internal wiring
	// ==================================================
	// Tag read path
	line_index_t rd_index;
	tag_t rd_tags [WAYS];
	logic [WAYS-1:0] rd_valid;

	// Lookup to result buffer, with credits flowing back
	logic push;
	fetch_addr_t push_addr;
	logic push_hit;
	way_t push_way;
	logic credit_return;

	// Buffer head to allocator
	logic pop;
	logic head_valid;
	fetch_addr_t head_addr;
	logic head_hit;
	way_t head_way;

	// Fill path into the tag array
	logic wr;
	fetch_addr_t wr_addr;
	way_t wr_way;

	icache_tag_ram u_tag_ram (
		.clk(clk), .rst(rst),
		.wr(wr), .wr_addr(wr_addr), .wr_way(wr_way),
		.rd_index(rd_index), .rd_tags(rd_tags), .rd_valid(rd_valid)
	);

	icache_lookup u_lookup (
		.clk(clk), .rst(rst),
		.req_valid(req_valid), .req_addr(req_addr), .req_ready(req_ready),
		.rd_index(rd_index), .rd_tags(rd_tags), .rd_valid(rd_valid),
		.push(push), .push_addr(push_addr), .push_hit(push_hit), .push_way(push_way),
		.credit_return(credit_return)
	);

	icache_result_fifo u_result_fifo (
		.clk(clk), .rst(rst),
		.push(push), .push_addr(push_addr), .push_hit(push_hit), .push_way(push_way),
		.pop(pop), .head_valid(head_valid), .head_addr(head_addr),
		.head_hit(head_hit), .head_way(head_way), .credit_return(credit_return)
	);

	icache_refill_alloc u_refill_alloc (
		.clk(clk), .rst(rst),
		.head_valid(head_valid), .head_addr(head_addr),
		.head_hit(head_hit), .head_way(head_way), .pop(pop),
		.rsp_valid(rsp_valid), .rsp_addr(rsp_addr), .rsp_hit(rsp_hit), .rsp_way(rsp_way),
		.rsp_credit(rsp_credit),
		.wr(wr), .wr_addr(wr_addr), .wr_way(wr_way)
	);

endmodule

// ==== verification/icache_chk.sv ====
/*
 * Concurrent assertions for the cache top level
 *  - response and fill outputs low after reset
 *  - no push into a full result buffer, lookup credits in range
 *  - fills only together with a response and a buffered entry
 */
`timescale 1ns/10ps

module icache_chk import icache_pkg::*; (
	input logic clk,
	input logic rst,
	input logic rsp_valid,
	input logic wr,
	input logic push,
	input credit_cnt_t fifo_count,
	input credit_cnt_t lookup_credits
);

	// Failure tally, visible from the testbench
	int error_count = 0;

	assert property (@(posedge clk) rst |=> (rsp_valid === 1'b0) && (wr === 1'b0))
	else begin
		error_count++;
		$error("rsp_valid or wr not low after reset");
	end

	// The lookup's credit counter is the only overflow guard
	assert property (@(posedge clk) disable iff (rst) push |-> fifo_count < RESULT_DEPTH)
	else begin
		error_count++;
		$error("push into a full result buffer");
	end

	assert property (@(posedge clk) disable iff (rst) lookup_credits <= RESULT_DEPTH)
	else begin
		error_count++;
		$error("lookup credit count above buffer depth");
	end

	// A fill pops the buffer head in the same cycle as its response
	assert property (@(posedge clk) disable iff (rst)
		wr |-> rsp_valid && (fifo_count != '0))
	else begin
		error_count++;
		$error("tag fill without a response or a buffered result");
	end

endmodule

bind icache_top icache_chk u_chk (
	.clk(clk), .rst(rst), .rsp_valid(rsp_valid), .wr(wr), .push(push),
	.fifo_count(u_result_fifo.count), .lookup_credits(u_lookup.credits)
);

// ==== verification/icache_tb.sv ====
/*
 * Testbench for the instruction-cache tag lookup
 *  - table of fetch addresses with expected hit, way and drain flag
 *  - reference model of tags, valid bits and victim counter
 *  - response checker in request order, random-delay credit driver
 */
`timescale 1ns/10ps

module icache_tb import icache_pkg::*; ();

	logic clk = 1'b0;
	logic rst;
	logic req_valid;
	fetch_addr_t req_addr;
	logic req_ready;
	logic rsp_valid;
	fetch_addr_t rsp_addr;
	logic rsp_hit;
	way_t rsp_way;
	logic rsp_credit;

	// Stimulus table and the queue of responses still expected
	fetch_addr_t tab_addr [$];
	logic tab_hit [$];
	way_t tab_way [$];
	logic tab_drain [$];
	fetch_addr_t exp_addr [$];
	logic exp_hit [$];
	way_t exp_way [$];

	// Reference model state
	tag_t ref_tag [LINES][WAYS];
	logic ref_valid [LINES][WAYS];
	way_t ref_victim;

	// Credit driver state, responses seen so far
	integer seed = 32'h9755_518b;
	logic credit_en;
	int pending_credits;
	int credit_delay;
	int rsp_count;

	icache_top dut (
		.clk(clk), .rst(rst),
		.req_valid(req_valid), .req_addr(req_addr), .req_ready(req_ready),
		.rsp_valid(rsp_valid), .rsp_addr(rsp_addr), .rsp_hit(rsp_hit), .rsp_way(rsp_way),
		.rsp_credit(rsp_credit)
	);

	always #50 clk = ~clk;

	// ==================================================
	// Helpers
	// ==================================================
	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp));
		end
	endtask

	function automatic fetch_addr_t make_addr(input tag_t t, input line_index_t s,
			input logic [5:0] off);
		return {t, s, off};
	endfunction

	task automatic add_entry(input fetch_addr_t a, input logic hit, input way_t way,
			input logic drain);
		tab_addr.push_back(a);
		tab_hit.push_back(hit);
		tab_way.push_back(way);
		tab_drain.push_back(drain);
	endtask

	// Expected values worked out by hand, set 0x12 unless noted
	task automatic load_table();
		// Cold misses fill ways 0 to 3
		add_entry(make_addr(18'h00101, 8'h12, 6'h04), 1'b0, 2'd0, 1'b1);
		add_entry(make_addr(18'h00102, 8'h12, 6'h00), 1'b0, 2'd1, 1'b1);
		add_entry(make_addr(18'h00103, 8'h12, 6'h08), 1'b0, 2'd2, 1'b1);
		add_entry(make_addr(18'h00104, 8'h12, 6'h00), 1'b0, 2'd3, 1'b1);
		// Repeats hit, another offset in the same line too
		add_entry(make_addr(18'h00101, 8'h12, 6'h00), 1'b1, 2'd0, 1'b1);
		add_entry(make_addr(18'h00102, 8'h12, 6'h00), 1'b1, 2'd1, 1'b1);
		add_entry(make_addr(18'h00103, 8'h12, 6'h00), 1'b1, 2'd2, 1'b1);
		add_entry(make_addr(18'h00104, 8'h12, 6'h00), 1'b1, 2'd3, 1'b1);
		add_entry(make_addr(18'h00102, 8'h12, 6'h3c), 1'b1, 2'd1, 1'b1);
		// Fifth tag evicts way 0, the evicted line comes back in way 1
		add_entry(make_addr(18'h00105, 8'h12, 6'h00), 1'b0, 2'd0, 1'b1);
		add_entry(make_addr(18'h00101, 8'h12, 6'h00), 1'b0, 2'd1, 1'b1);
		// Back-pressure batch, misses only in sets with nothing else in flight
		add_entry(make_addr(18'h00103, 8'h12, 6'h00), 1'b1, 2'd2, 1'b0);
		add_entry(make_addr(18'h00200, 8'h20, 6'h00), 1'b0, 2'd2, 1'b0);
		add_entry(make_addr(18'h00201, 8'h21, 6'h08), 1'b0, 2'd3, 1'b0);
		add_entry(make_addr(18'h00104, 8'h12, 6'h10), 1'b1, 2'd3, 1'b0);
		add_entry(make_addr(18'h00202, 8'h22, 6'h00), 1'b0, 2'd0, 1'b0);
		add_entry(make_addr(18'h00105, 8'h12, 6'h20), 1'b1, 2'd0, 1'b0);
		add_entry(make_addr(18'h00203, 8'h23, 6'h00), 1'b0, 2'd1, 1'b0);
		// After the second reset a cached line misses into way 0
		add_entry(make_addr(18'h00103, 8'h12, 6'h00), 1'b0, 2'd0, 1'b1);
	endtask

	// ==================================================
	// Reference model
	// ==================================================
	task automatic model_reset();
		for (int s = 0; s < LINES; s++) begin
			for (int w = 0; w < WAYS; w++) begin
				ref_valid[s][w] = 1'b0;
			end
		end
		ref_victim = '0;
	endtask

	// Lowest matching way wins, a miss fills the global victim way
	task automatic model_lookup(input fetch_addr_t a, output logic hit, output way_t way);
		tag_t t;
		line_index_t s;
		t = a[31:TAGBIT];
		s = a[TAGBIT-1:LOBIT];
		hit = 1'b0;
		way = ref_victim;
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (ref_valid[s][w] && ref_tag[s][w] == t) begin
				hit = 1'b1;
				way = way_t'(w);
			end
		end
		if (!hit) begin
			ref_tag[s][way] = t;
			ref_valid[s][way] = 1'b1;
			ref_victim = ref_victim + 1'b1;
		end
	endtask

	// ==================================================
	// Drivers
	// ==================================================
	task automatic apply_reset();
		rst = 1'b1;
		repeat (2) @(posedge clk);
		#5;
		rst = 1'b0;
	endtask

	// Holds valid and address until the handshake completes
	task automatic send_request(input fetch_addr_t a);
		int waited;
		waited = 0;
		req_valid = 1'b1;
		req_addr = a;
		while (!req_ready) begin
			@(posedge clk);
			#5;
			waited++;
			if (waited > 200) fail_run("Timed out waiting for req_ready to accept a request");
		end
		@(posedge clk);
		#5;
		req_valid = 1'b0;
	endtask

	// Every response in, every credit handed back
	task automatic wait_idle();
		int waited;
		waited = 0;
		while (exp_addr.size() != 0 || pending_credits != 0) begin
			@(posedge clk);
			#5;
			waited++;
			if (waited > 500) fail_run("Timed out waiting for outstanding responses");
		end
	endtask

	task automatic run_entry(input int i);
		logic hit;
		way_t way;
		model_lookup(tab_addr[i], hit, way);
		check_value("table hit against model", tab_hit[i], hit);
		check_value("table way against model", tab_way[i], way);
		exp_addr.push_back(tab_addr[i]);
		exp_hit.push_back(tab_hit[i]);
		exp_way.push_back(tab_way[i]);
		send_request(tab_addr[i]);
		if (tab_drain[i]) wait_idle();
	endtask

	// Decides on the edge, drives one pulse per response after a random delay
	always begin
		logic pulse;
		@(posedge clk);
		pulse = 1'b0;
		if (credit_en && pending_credits > 0) begin
			if (credit_delay == 0) begin
				pulse = 1'b1;
				pending_credits--;
				credit_delay = $unsigned($random(seed)) % 4;
			end else begin
				credit_delay--;
			end
		end
		#5;
		rsp_credit = pulse;
	end

	// Responses are sampled mid-cycle and matched in request order
	always @(negedge clk) begin
		if (dut.u_chk.error_count != 0) fail_run("An assertion in the bound checker failed");
		if (!rst && rsp_valid === 1'b1) begin
			if (exp_addr.size() == 0) begin
				fail_run("A response arrived with no request outstanding");
			end else begin
				check_value("rsp_addr", rsp_addr, exp_addr.pop_front());
				check_value("rsp_hit", rsp_hit, exp_hit.pop_front());
				check_value("rsp_way", rsp_way, exp_way.pop_front());
				rsp_count++;
				pending_credits++;
			end
		end
	end

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin
		rst = 1'b1;
		req_valid = 1'b0;
		req_addr = '0;
		rsp_credit = 1'b0;
		credit_en = 1'b1;
		pending_credits = 0;
		credit_delay = 0;
		rsp_count = 0;
		load_table();
		model_reset();
		apply_reset();
		// Cold misses, repeats and round-robin replacement
		for (int i = 0; i < 11; i++) begin
			run_entry(i);
		end
		// Sink stops returning credits, buffer and lookup fill up
		credit_en = 1'b0;
		rsp_count = 0;
		for (int i = 11; i < 18; i++) begin
			run_entry(i);
		end
		repeat (20) @(posedge clk);
		#5;
		check_value("responses without credit return", rsp_count, RSP_CREDITS);
		check_value("req_ready with buffer full", req_ready, 1'b0);
		credit_en = 1'b1;
		wait_idle();
		// Second reset clears the valid bits and the victim counter
		apply_reset();
		model_reset();
		run_entry(18);
		if (dut.u_chk.error_count != 0) begin
			fail_run("An assertion in the bound checker failed");
		end else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule
